// File: rtl/cache_pkg.sv
package cache_pkg;

  // fixed geometry: 2 ways x 256 sets x 16-byte lines
  localparam int num_sets       = 256;
  localparam int index_w        = 8;
  localparam int tag_w          = 20;
  localparam int offset_w       = 4;
  localparam int words_per_line = 4;

  typedef logic [31:0]        word_t;
  typedef logic [index_w-1:0] index_t;
  typedef logic [tag_w-1:0]   tag_t;

  // word 0 in the low 32 bits
  typedef word_t [words_per_line-1:0] line_t;

  // byte address, or tag/index/offset fields
  // offset[3:2] picks the word, offset[1:0] unused
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      tag_t                tag;
      index_t              index;
      logic [offset_w-1:0] offset;
    } f;
  } cache_addr_t;

  typedef enum logic [2:0] {
    s_idle    = 3'd0,
    s_lookup  = 3'd1,
    s_miss    = 3'd2,
    s_replace = 3'd3,
    s_refill  = 3'd4
  } state_t;

  // any nonzero value works
  localparam logic [3:0] lfsr_seed = 4'b1001;

endpackage

// File: rtl/cache_way.sv
`timescale 1ns/1ns

module cache_way (
  input  logic               clk_g,
  input  logic               resetn,
  input  cache_pkg::index_t  index,
  input  logic               rd_en,
  input  logic [3:0]         bank_we,
  input  logic [3:0]         byte_we,
  input  cache_pkg::word_t   bank_wdata,
  input  logic               tag_we,
  input  cache_pkg::tag_t    tag_wdata,
  input  logic               dirty_we,
  input  logic               dirty_wdata,
  output cache_pkg::tag_t    tag,
  output logic               valid,
  output logic               dirty,
  output cache_pkg::line_t   line
);
  import cache_pkg::*;

  tag_t  tag_mem  [num_sets];
  word_t data_mem [words_per_line][num_sets];

  logic [num_sets-1:0] valid_bits;
  logic [num_sets-1:0] dirty_bits;

  // tag and data arrays
  always_ff @(posedge clk_g) begin
    if (tag_we) begin
      tag_mem[index] <= tag_wdata;
    end
    for (int b = 0; b < words_per_line; b++) begin
      for (int k = 0; k < 4; k++) begin
        if (bank_we[b] && byte_we[k]) begin
          data_mem[b][index][8*k +: 8] <= bank_wdata[8*k +: 8];
        end
      end
    end
  end

  // a tag write always installs a line, so it also sets valid
  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (tag_we) begin
        valid_bits[index] <= 1'b1;
      end
      if (dirty_we) begin
        dirty_bits[index] <= dirty_wdata;
      end
    end
  end

  // registered read of the indexed set
  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      valid <= 1'b0;
      dirty <= 1'b0;
    end else if (rd_en) begin
      valid <= valid_bits[index];
      dirty <= dirty_bits[index];
    end
  end

  // held until the next read, doubles as the writeback buffer
  always_ff @(posedge clk_g) begin
    if (rd_en) begin
      tag <= tag_mem[index];
      for (int b = 0; b < words_per_line; b++) begin
        line[b] <= data_mem[b][index];
      end
    end
  end

  // controller never requests a bank write with an empty byte mask
  a_bank_we_has_bytes: assert property (
    @(posedge clk_g) disable iff (!resetn)
    (|bank_we) |-> (|byte_we)
  ) else $error("bank_we %h with empty byte_we", bank_we);

endmodule

// File: rtl/way_merge.sv
`timescale 1ns/1ns

module way_merge (
  input  cache_pkg::tag_t   tag0,
  input  logic              valid0,
  input  logic              dirty0,
  input  cache_pkg::line_t  line0,
  input  cache_pkg::tag_t   tag1,
  input  logic              valid1,
  input  logic              dirty1,
  input  cache_pkg::line_t  line1,
  input  cache_pkg::tag_t   req_tag,
  input  logic [1:0]        word_sel,
  input  logic              rand_way,
  output logic              hit,
  output logic              hit_way,
  output cache_pkg::word_t  hit_word,
  output logic              victim_way,
  output logic              victim_dirty,
  output cache_pkg::tag_t   victim_tag,
  output cache_pkg::line_t  victim_line
);
  import cache_pkg::*;

  logic hit0;
  logic hit1;

  assign hit0 = valid0 && (tag0 == req_tag);
  assign hit1 = valid1 && (tag1 == req_tag);

  assign hit      = hit0 || hit1;
  assign hit_way  = hit1;
  assign hit_word = hit1 ? line1[word_sel] : line0[word_sel];

  // fill empty ways first, way 0 before way 1
  assign victim_way = !valid0 ? 1'b0 :
                      !valid1 ? 1'b1 :
                      rand_way;

  // an invalid line never needs writing back
  assign victim_dirty = victim_way ? (valid1 && dirty1) : (valid0 && dirty0);
  assign victim_tag   = victim_way ? tag1 : tag0;
  assign victim_line  = victim_way ? line1 : line0;

  // same tag installed in both ways would mean a broken refill
  always_comb begin
    a_single_hit: assert (!(hit0 && hit1))
      else $error("both ways hit tag %h", req_tag);
  end

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
  input  logic                   clk_g,
  input  logic                   resetn,
  input  logic                   valid,
  input  logic                   op,
  input  cache_pkg::cache_addr_t addr,
  input  logic [3:0]             wstrb,
  input  cache_pkg::word_t       wdata,
  input  logic                   hit,
  input  logic                   hit_way,
  input  cache_pkg::word_t       hit_word,
  input  logic                   victim_way,
  input  logic                   victim_dirty,
  input  cache_pkg::tag_t        victim_tag,
  input  cache_pkg::line_t       victim_line,
  input  logic                   wr_rdy,
  input  logic                   rd_rdy,
  input  logic                   ret_valid,
  input  logic                   ret_last,
  input  cache_pkg::word_t       ret_data,
  output cache_pkg::index_t      index,
  output logic                   rd_en,
  output cache_pkg::tag_t        req_tag,
  output logic [1:0]             word_sel,
  output logic                   rand_way,
  output logic [3:0]             way0_bank_we,
  output logic [3:0]             way1_bank_we,
  output logic [3:0]             byte_we,
  output cache_pkg::word_t       bank_wdata,
  output logic                   way0_tag_we,
  output logic                   way1_tag_we,
  output logic                   dirty_we0,
  output logic                   dirty_we1,
  output logic                   dirty_wdata,
  output logic                   addr_ok,
  output logic                   data_ok,
  output cache_pkg::word_t       rdata,
  output logic                   rd_req,
  output logic [31:0]            rd_addr,
  output logic                   wr_req,
  output logic [31:0]            wr_addr,
  output cache_pkg::line_t       wr_data
);
  import cache_pkg::*;

  state_t      state;
  state_t      state_nxt;
  cache_addr_t req_addr;
  logic        req_op;
  logic [3:0]  req_wstrb;
  word_t       req_wdata;
  logic        miss_way;
  logic [3:0]  lfsr;
  logic [1:0]  beat_cnt;
  logic        accept;
  logic        hit_store;
  logic        beat_hit;
  logic        fill_done;
  logic [3:0]  hit_bank_we;
  logic [3:0]  refill_bank_we;
  word_t       merged_word;

  assign accept = (state == s_idle) && valid;

  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      state <= s_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      s_idle:    if (valid) state_nxt = s_lookup;
      s_lookup:  state_nxt = hit ? s_idle : s_miss;
      s_miss:    if (wr_rdy) state_nxt = s_replace;
      s_replace: if (rd_rdy) state_nxt = s_refill;
      s_refill:  if (ret_valid && ret_last) state_nxt = s_idle;
      default:   state_nxt = s_idle;
    endcase
  end

  always_ff @(posedge clk_g) begin
    if (accept) begin
      req_addr  <= addr;
      req_op    <= op;
      req_wstrb <= wstrb;
      req_wdata <= wdata;
    end
  end

  // victim fixed when the miss is detected
  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      miss_way <= 1'b0;
    end else if (state == s_lookup && !hit) begin
      miss_way <= victim_way;
    end
  end

  // x^4 + x^3 + 1
  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      lfsr <= lfsr_seed;
    end else begin
      lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
    end
  end

  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      beat_cnt <= 2'd0;
    end else if (state == s_replace && rd_rdy) begin
      beat_cnt <= 2'd0;
    end else if (state == s_refill && ret_valid) begin
      beat_cnt <= beat_cnt + 2'd1;
    end
  end

  // ways read their storage on the accepting edge
  assign index    = (state == s_idle) ? addr.f.index : req_addr.f.index;
  assign rd_en    = accept;
  assign req_tag  = req_addr.f.tag;
  assign word_sel = req_addr.f.offset[3:2];

  // held after lookup so the merge keeps naming the same victim
  assign rand_way = (state == s_lookup) ? lfsr[0] : miss_way;

  assign hit_store      = (state == s_lookup) && hit && req_op;
  assign beat_hit       = (state == s_refill) && ret_valid && (beat_cnt == word_sel);
  assign fill_done      = (state == s_refill) && ret_valid && ret_last;
  assign hit_bank_we    = (hit_store && |req_wstrb) ? (4'b0001 << word_sel) : 4'b0000;
  assign refill_bank_we = (state == s_refill && ret_valid) ? (4'b0001 << beat_cnt) : 4'b0000;

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      merged_word[8*k +: 8] = req_wstrb[k] ? req_wdata[8*k +: 8] : ret_data[8*k +: 8];
    end
  end

  assign way0_bank_we = hit_way ? refill_bank_we & {4{!miss_way}}
                                : hit_bank_we | (refill_bank_we & {4{!miss_way}});
  assign way1_bank_we = hit_way ? hit_bank_we | (refill_bank_we & {4{miss_way}})
                                : refill_bank_we & {4{miss_way}};

  assign byte_we    = (state == s_refill) ? 4'hf : req_wstrb;
  assign bank_wdata = (state != s_refill)             ? req_wdata :
                      (req_op && beat_cnt == word_sel) ? merged_word :
                      ret_data;

  assign way0_tag_we = fill_done && !miss_way;
  assign way1_tag_we = fill_done && miss_way;
  assign dirty_we0   = (hit_store && !hit_way) || way0_tag_we;
  assign dirty_we1   = (hit_store && hit_way) || way1_tag_we;
  assign dirty_wdata = req_op;

  assign addr_ok = (state == s_idle);
  assign data_ok = ((state == s_lookup) && hit) || beat_hit;
  assign rdata   = (state == s_refill) ? ret_data : hit_word;

  assign rd_req  = (state == s_replace);
  assign rd_addr = {req_addr.f.tag, req_addr.f.index, {offset_w{1'b0}}};
  assign wr_req  = (state == s_miss) && wr_rdy && victim_dirty;
  assign wr_addr = {victim_tag, req_addr.f.index, {offset_w{1'b0}}};
  assign wr_data = victim_line;

  // one writeback pulse per miss, then the line is requested
  a_wr_req_pulse: assert property (
    @(posedge clk_g) disable iff (!resetn)
    wr_req |=> !wr_req && rd_req
  ) else $error("wr_req not followed by rd_req");

  a_data_ok_pulse: assert property (
    @(posedge clk_g) disable iff (!resetn)
    data_ok |=> !data_ok
  ) else $error("data_ok high for more than one cycle");

  // beats only arrive after the read request has been taken
  a_ret_after_req: assert property (
    @(posedge clk_g) disable iff (!resetn)
    ret_valid |-> (state == s_refill) && !rd_req
  ) else $error("ret_valid outside refill, state %0d", state);

endmodule

// File: rtl/cache_top.sv
`timescale 1ns/1ns

module cache_top (
  input  logic                   clk_g,
  input  logic                   resetn,
  input  logic                   valid,
  input  logic                   op,
  input  cache_pkg::cache_addr_t addr,
  input  logic [3:0]             wstrb,
  input  cache_pkg::word_t       wdata,
  output logic                   addr_ok,
  output logic                   data_ok,
  output cache_pkg::word_t       rdata,
  output logic                   rd_req,
  output logic [31:0]            rd_addr,
  input  logic                   rd_rdy,
  input  logic                   ret_valid,
  input  logic                   ret_last,
  input  cache_pkg::word_t       ret_data,
  output logic                   wr_req,
  output logic [31:0]            wr_addr,
  output cache_pkg::line_t       wr_data,
  input  logic                   wr_rdy
);
  import cache_pkg::*;

  // controller to ways
  index_t     index;
  logic       rd_en;
  tag_t       req_tag;
  logic [1:0] word_sel;
  logic       rand_way;
  logic [3:0] way0_bank_we;
  logic [3:0] way1_bank_we;
  logic [3:0] byte_we;
  word_t      bank_wdata;
  logic       way0_tag_we;
  logic       way1_tag_we;
  logic       dirty_we0;
  logic       dirty_we1;
  logic       dirty_wdata;

  // way read results
  tag_t  tag0;
  tag_t  tag1;
  logic  valid0;
  logic  valid1;
  logic  dirty0;
  logic  dirty1;
  line_t line0;
  line_t line1;

  // merge results
  logic  hit;
  logic  hit_way;
  word_t hit_word;
  logic  victim_way;
  logic  victim_dirty;
  tag_t  victim_tag;
  line_t victim_line;

  cache_way u_way0 (
    .clk_g       (clk_g),
    .resetn      (resetn),
    .index       (index),
    .rd_en       (rd_en),
    .bank_we     (way0_bank_we),
    .byte_we     (byte_we),
    .bank_wdata  (bank_wdata),
    .tag_we      (way0_tag_we),
    .tag_wdata   (req_tag),
    .dirty_we    (dirty_we0),
    .dirty_wdata (dirty_wdata),
    .tag         (tag0),
    .valid       (valid0),
    .dirty       (dirty0),
    .line        (line0)
  );

  cache_way u_way1 (
    .clk_g       (clk_g),
    .resetn      (resetn),
    .index       (index),
    .rd_en       (rd_en),
    .bank_we     (way1_bank_we),
    .byte_we     (byte_we),
    .bank_wdata  (bank_wdata),
    .tag_we      (way1_tag_we),
    .tag_wdata   (req_tag),
    .dirty_we    (dirty_we1),
    .dirty_wdata (dirty_wdata),
    .tag         (tag1),
    .valid       (valid1),
    .dirty       (dirty1),
    .line        (line1)
  );

  way_merge u_merge (
    .tag0         (tag0),
    .valid0       (valid0),
    .dirty0       (dirty0),
    .line0        (line0),
    .tag1         (tag1),
    .valid1       (valid1),
    .dirty1       (dirty1),
    .line1        (line1),
    .req_tag      (req_tag),
    .word_sel     (word_sel),
    .rand_way     (rand_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_word     (hit_word),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line)
  );

  cache_ctrl u_ctrl (
    .clk_g        (clk_g),
    .resetn       (resetn),
    .valid        (valid),
    .op           (op),
    .addr         (addr),
    .wstrb        (wstrb),
    .wdata        (wdata),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_word     (hit_word),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .wr_rdy       (wr_rdy),
    .rd_rdy       (rd_rdy),
    .ret_valid    (ret_valid),
    .ret_last     (ret_last),
    .ret_data     (ret_data),
    .index        (index),
    .rd_en        (rd_en),
    .req_tag      (req_tag),
    .word_sel     (word_sel),
    .rand_way     (rand_way),
    .way0_bank_we (way0_bank_we),
    .way1_bank_we (way1_bank_we),
    .byte_we      (byte_we),
    .bank_wdata   (bank_wdata),
    .way0_tag_we  (way0_tag_we),
    .way1_tag_we  (way1_tag_we),
    .dirty_we0    (dirty_we0),
    .dirty_we1    (dirty_we1),
    .dirty_wdata  (dirty_wdata),
    .addr_ok      (addr_ok),
    .data_ok      (data_ok),
    .rdata        (rdata),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr),
    .wr_req       (wr_req),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
  output logic clk_g,
  output logic resetn
);

  // 4 ns period
  initial begin
    clk_g = 1'b0;
    forever #2 clk_g = ~clk_g;
  end

  // low for four rising edges, released just after the fourth
  initial begin
    resetn = 1'b0;
    repeat (4) @(posedge clk_g);
    #1 resetn = 1'b1;
  end

endmodule

// File: bench/mem_model.sv
`timescale 1ns/1ns

module mem_model (
  input  logic              clk_g,
  input  logic              resetn,
  input  logic              rd_req,
  input  logic [31:0]       rd_addr,
  output logic              rd_rdy,
  output logic              ret_valid,
  output logic              ret_last,
  output cache_pkg::word_t  ret_data,
  input  logic              wr_req,
  input  logic [31:0]       wr_addr,
  input  cache_pkg::line_t  wr_data,
  output logic              wr_rdy
);
  import cache_pkg::*;

  // only written words are stored, the rest follow the fill rule
  word_t       mem [logic [29:0]];
  logic [31:0] rng_state = 32'd77;
  logic        rd_taken;
  logic        busy;
  logic [1:0]  beat;
  logic [31:0] line_addr;

  function automatic word_t read_word(logic [31:0] a);
    if (mem.exists(a[31:2])) begin
      return mem[a[31:2]];
    end
    return {a[15:0], ~a[15:0]};
  endfunction

  function logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  initial begin
    rd_rdy    = 1'b0;
    wr_rdy    = 1'b0;
    ret_valid = 1'b0;
    ret_last  = 1'b0;
    ret_data  = '0;
    rd_taken  = 1'b0;
    busy      = 1'b0;
    beat      = 2'd0;
    line_addr = '0;
  end

  // handshakes sampled mid-cycle
  always @(negedge clk_g) begin
    rd_taken = resetn && rd_req && rd_rdy;
    if (rd_taken) begin
      line_addr = rd_addr;
    end
    if (resetn && wr_req && wr_rdy) begin
      for (int k = 0; k < 4; k++) begin
        mem[wr_addr[31:2] + 30'(k)] = wr_data[k];
      end
    end
  end

  always @(posedge clk_g) begin
    logic [31:0] r;
    #1;
    r = lcg_next();
    if (!resetn) begin
      busy = 1'b0;
      beat = 2'd0;
    end else begin
      // the beat driven last cycle was taken at this edge
      if (ret_valid) begin
        if (ret_last) begin
          busy = 1'b0;
        end
        beat = beat + 2'd1;
      end
      if (rd_taken) begin
        busy = 1'b1;
        beat = 2'd0;
      end
    end
    ret_valid = busy && (r[19:18] != 2'b00);
    ret_last  = ret_valid && (beat == 2'd3);
    ret_data  = ret_valid ? read_word(line_addr + {28'd0, beat, 2'b00}) : '0;
    rd_rdy    = (r[21:20] != 2'b00);
    wr_rdy    = (r[23:22] != 2'b00);
  end

endmodule

// File: bench/tb_cache.sv
`timescale 1ns/1ns

module tb_cache;
  import cache_pkg::*;

  localparam int n_steps  = 14;
  localparam int n_random = 200;
  localparam int clk_ns   = 4;

  typedef struct packed {
    logic        is_write;
    logic [31:0] addr;
    logic [3:0]  strb;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic [1:0]  miss;
    logic [1:0]  wback;
  } step_t;

  logic        clk_g;
  logic        resetn;
  logic        valid;
  logic        op;
  logic [31:0] addr;
  logic [3:0]  wstrb;
  word_t       wdata;
  logic        addr_ok;
  logic        data_ok;
  word_t       rdata;
  logic        rd_req;
  logic [31:0] rd_addr;
  logic        rd_rdy;
  logic        ret_valid;
  logic        ret_last;
  word_t       ret_data;
  logic        wr_req;
  logic [31:0] wr_addr;
  line_t       wr_data;
  logic        wr_rdy;

  word_t       shadow [logic [29:0]];
  logic [31:0] rng_state = 32'd77;
  logic [31:0] cur_line = '0;
  int          rd_count = 0;
  int          wr_count = 0;
  logic [19:0] tags [4] = '{20'h00001, 20'h00002, 20'h00003, 20'h80004};

  // miss and wback hold the handshake count expected per step
  // a value of 2 skips the count check
  step_t steps [n_steps] = '{
    // op, address, strobe, write data, expected read, miss, wback
    '{1'b0, 32'h0000_1058, 4'h0, 32'h0000_0000, 32'h1058_efa7, 2'd1, 2'd0},
    '{1'b0, 32'h0000_1058, 4'h0, 32'h0000_0000, 32'h1058_efa7, 2'd0, 2'd0},
    '{1'b0, 32'h0000_1050, 4'h0, 32'h0000_0000, 32'h1050_efaf, 2'd0, 2'd0},
    '{1'b1, 32'h0000_1058, 4'h5, 32'haabb_ccdd, 32'h0000_0000, 2'd0, 2'd0},
    '{1'b0, 32'h0000_1058, 4'h0, 32'h0000_0000, 32'h10bb_efdd, 2'd0, 2'd0},
    '{1'b1, 32'h0000_2054, 4'h8, 32'h1122_3344, 32'h0000_0000, 2'd1, 2'd0},
    '{1'b0, 32'h0000_2054, 4'h0, 32'h0000_0000, 32'h1154_dfab, 2'd0, 2'd0},
    '{1'b0, 32'h0000_2050, 4'h0, 32'h0000_0000, 32'h2050_dfaf, 2'd0, 2'd0},
    '{1'b1, 32'h0000_305c, 4'hf, 32'hcafe_f00d, 32'h0000_0000, 2'd1, 2'd1},
    '{1'b0, 32'h0000_305c, 4'h0, 32'h0000_0000, 32'hcafe_f00d, 2'd0, 2'd0},
    '{1'b0, 32'h0000_3050, 4'h0, 32'h0000_0000, 32'h3050_cfaf, 2'd0, 2'd0},
    '{1'b0, 32'h0000_1058, 4'h0, 32'h0000_0000, 32'h10bb_efdd, 2'd2, 2'd2},
    '{1'b0, 32'h0000_2054, 4'h0, 32'h0000_0000, 32'h1154_dfab, 2'd2, 2'd2},
    '{1'b0, 32'h0000_1050, 4'h0, 32'h0000_0000, 32'h1050_efaf, 2'd2, 2'd2}
  };

  clk_gen u_clk (
    .clk_g  (clk_g),
    .resetn (resetn)
  );

  mem_model u_mem (
    .clk_g     (clk_g),
    .resetn    (resetn),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_rdy    (rd_rdy),
    .ret_valid (ret_valid),
    .ret_last  (ret_last),
    .ret_data  (ret_data),
    .wr_req    (wr_req),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_rdy    (wr_rdy)
  );

  cache_top DUT (
    .clk_g     (clk_g),
    .resetn    (resetn),
    .valid     (valid),
    .op        (op),
    .addr      (addr),
    .wstrb     (wstrb),
    .wdata     (wdata),
    .addr_ok   (addr_ok),
    .data_ok   (data_ok),
    .rdata     (rdata),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_rdy    (rd_rdy),
    .ret_valid (ret_valid),
    .ret_last  (ret_last),
    .ret_data  (ret_data),
    .wr_req    (wr_req),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_rdy    (wr_rdy)
  );

  function logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // unwritten words keep the memory fill rule
  function automatic word_t expected_word(logic [31:0] a);
    if (shadow.exists(a[31:2])) begin
      return shadow[a[31:2]];
    end
    return {a[15:0], ~a[15:0]};
  endfunction

  function automatic word_t apply_strobe(word_t old, word_t d, logic [3:0] strb);
    word_t res;
    for (int k = 0; k < 4; k++) begin
      res[8*k +: 8] = strb[k] ? d[8*k +: 8] : old[8*k +: 8];
    end
    return res;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [127:0] actual,
                       input logic [127:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one request from acceptance to data_ok
  // the shadow follows each write
  task automatic run_request(input logic wr, input logic [31:0] a, input logic [3:0] strb,
                             input word_t d, output word_t got);
    @(posedge clk_g);
    #1;
    while (!addr_ok) begin
      @(posedge clk_g);
      #1;
    end
    cur_line = {a[31:4], 4'h0};
    valid = 1'b1;
    op    = wr;
    addr  = a;
    wstrb = strb;
    wdata = d;
    @(posedge clk_g);
    #1;
    valid = 1'b0;
    @(negedge clk_g);
    while (!data_ok) begin
      @(negedge clk_g);
    end
    got = rdata;
    if (wr) begin
      shadow[a[31:2]] = apply_strobe(expected_word(a), d, strb);
    end
  endtask

  // memory side traffic
  always @(negedge clk_g) begin
    if (resetn) begin
      if (rd_req && rd_rdy) begin
        rd_count++;
        check("rd_addr", rd_addr, cur_line);
      end
      if (wr_req) begin
        wr_count++;
        // the victim shares the request's set but not its tag
        check("wr_addr", wr_addr[11:0], cur_line[11:0]);
        check("wr_addr tag differs from request", wr_addr[31:12] != cur_line[31:12], 1'b1);
        for (int k = 0; k < 4; k++) begin
          check($sformatf("wr_data[%0d]", k), wr_data[k], expected_word(wr_addr + 32'(4 * k)));
        end
      end
    end
  end

  initial begin
    #((n_steps + n_random) * 200 * clk_ns);
    stop_run("timeout: the cache stopped answering requests");
  end

  initial begin
    word_t       got;
    logic [31:0] r;
    logic [31:0] a;
    int          rd_before;
    int          wr_before;
    valid = 1'b0;
    op    = 1'b0;
    addr  = '0;
    wstrb = '0;
    wdata = '0;
    @(posedge resetn);
    @(negedge clk_g);
    check("addr_ok", addr_ok, 1'b1);
    check("data_ok", data_ok, 1'b0);
    check("rd_req", rd_req, 1'b0);
    check("wr_req", wr_req, 1'b0);

    for (int i = 0; i < n_steps; i++) begin
      rd_before = rd_count;
      wr_before = wr_count;
      run_request(steps[i].is_write, steps[i].addr, steps[i].strb, steps[i].data, got);
      if (!steps[i].is_write) begin
        check("rdata", got, steps[i].exp_data);
      end
      if (steps[i].miss != 2'd2) begin
        check("rd_req count", rd_count - rd_before, steps[i].miss);
      end
      if (steps[i].wback != 2'd2) begin
        check("wr_req count", wr_count - wr_before, steps[i].wback);
      end
    end

    // two sets and four tags so both ways get replaced often
    for (int n = 0; n < n_random; n++) begin
      r = lcg_next();
      a = {tags[r[17:16]], (r[18] ? 8'h05 : 8'ha3), r[20:19], 2'b00};
      run_request(r[21], a, r[25:22], lcg_next(), got);
      if (!r[21]) begin
        check("rdata", got, expected_word(a));
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// File: cache.f
rtl/cache_pkg.sv
rtl/cache_way.sv
rtl/way_merge.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
bench/clk_gen.sv
bench/mem_model.sv
bench/tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache
FLAGS     ?= --assert -Wno-fatal
FILELIST  ?= cache.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the run passes only if the pass line shows up in the output
run: build
	out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
